// File: ob.f
+incdir+design
design/ob_pkg.sv
design/ob_book_table.sv
design/ob_match.sv
design/ob_cntrl.sv
design/ob_top.sv
testbench/tb_ob.sv

// File: run_sim.sh
#!/bin/sh
# Builds the order book testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -f ob.f --top-module tb_ob; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ob > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$log"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0

// File: testbench/ob_golden.txt
# C opcode uid price quantity (opcode 0 nop 1 spread 2 buy 3 sell 4 pop bid 5 pop ask)
# R uid status f0 f1 f2 (status 0 okay 1 bad 2 badpop 3 full; spread, entry or trade fields)
C 0 1 0 0
R 1 0 0 0 0
C 1 2 0 0
R 2 1 0 0 0
C 4 3 0 0
R 3 2 0 0 0
C 2 10 100 5
R 10 0 0 0 0
C 2 11 100 3
R 11 0 0 0 0
C 3 20 110 6
R 20 0 0 0 0
C 3 21 108 2
R 21 0 0 0 0
C 3 22 112 1
R 22 0 0 0 0
C 3 23 115 1
R 23 0 0 0 0
C 3 24 111 9
R 24 3 0 0 0
C 1 12 0 0
R 12 0 100 108 0
C 4 13 0 0
R 13 0 10 100 5
C 2 30 111 10
R 30 0 0 0 0
R 255 0 30 21 2
R 255 0 30 20 6
C 3 40 100 7
R 40 0 0 0 0
R 255 0 30 40 2
R 255 0 11 40 3
C 5 41 0 0
R 41 0 40 100 2
C 4 42 0 0
R 42 2 0 0 0
C 5 43 0 0
R 43 0 22 112 1

// File: testbench/tb_ob.sv
// Order book testbench
// Replays golden command records and checks each response in order

`include "ob_defs.svh"

module tb_ob;

  timeunit 1ns;
  timeprecision 100ps;

  import ob_pkg::*;

  // Cycle budget for any single wait
  localparam int wait_limit = 200;

  // How the result word of an expected response is decoded
  localparam int kind_none   = 0;
  localparam int kind_spread = 1;
  localparam int kind_pop    = 2;
  localparam int kind_trade  = 3;

  localparam int uid_none = int'(`OB_UID_NONE);

  logic        clk       = 1'b0;
  logic        arst_n    = 1'b0;
  logic        cmd_valid = 1'b0;
  cmd_t        cmd       = '0;
  logic        cmd_ready;
  logic        rsp_valid;
  rsp_t        rsp;
  logic        rsp_ready = 1'b0;
  logic [31:0] lcg_state = 32'd50604;

  // Commands from the golden file
  int cmd_op_q[$];
  int cmd_uid_q[$];
  int cmd_price_q[$];
  int cmd_qty_q[$];

  // Expected responses in arrival order
  int exp_uid_q[$];
  int exp_status_q[$];
  int exp_kind_q[$];
  int exp_f0_q[$];
  int exp_f1_q[$];
  int exp_f2_q[$];

  int rsp_count = 0;

  ob_top u_ob_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Random back-pressure with ready about three cycles in four
  always @(posedge clk) begin
    lcg_state = lcg_next(lcg_state);
    rsp_ready <= (lcg_state[31:30] != 2'b00);
  end

  task automatic stop_on_failure();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("[ERROR] time %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic load_golden();
    int          fd;
    int          rc;
    int          a, b, c, d, e;
    int          last_op;
    int          kind;
    logic [7:0]  tag;
    logic [959:0] skip_line;
    fd = $fopen("testbench/ob_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the golden file testbench/ob_golden.txt");
      stop_on_failure();
    end
    last_op = 0;
    rc = $fscanf(fd, " %c", tag);
    while (rc == 1) begin
      if (tag == "#") begin
        rc = $fgets(skip_line, fd);
      end else if (tag == "C") begin
        rc = $fscanf(fd, "%d %d %d %d", a, b, c, d);
        if (rc != 4) begin
          $display("Malformed command record in the golden file");
          stop_on_failure();
        end
        cmd_op_q.push_back(a);
        cmd_uid_q.push_back(b);
        cmd_price_q.push_back(c);
        cmd_qty_q.push_back(d);
        last_op = a;
      end else if (tag == "R") begin
        rc = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
        if (rc != 5) begin
          $display("Malformed response record in the golden file");
          stop_on_failure();
        end
        // Decode follows the command that produced it
        if (a == uid_none) begin
          kind = kind_trade;
        end else if (b == int'(S_Okay) && last_op == int'(Op_QryBidAsk)) begin
          kind = kind_spread;
        end else if (b == int'(S_Okay) &&
                     (last_op == int'(Op_PopTopBid) || last_op == int'(Op_PopTopAsk))) begin
          kind = kind_pop;
        end else begin
          kind = kind_none;
        end
        exp_uid_q.push_back(a);
        exp_status_q.push_back(b);
        exp_kind_q.push_back(kind);
        exp_f0_q.push_back(c);
        exp_f1_q.push_back(d);
        exp_f2_q.push_back(e);
      end else begin
        $display("Unknown record tag in the golden file");
        stop_on_failure();
      end
      rc = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  // Offer one command and hold it until the DUT takes it
  task automatic send_command(input int k);
    int   waited;
    cmd_t next_cmd;
    next_cmd                  = '0;
    next_cmd.opcode           = opcode_t'(cmd_op_q[k]);
    next_cmd.uid              = uid_t'(cmd_uid_q[k]);
    next_cmd.operand.uid      = uid_t'(cmd_uid_q[k]);
    next_cmd.operand.price    = price_t'(cmd_price_q[k]);
    next_cmd.operand.quantity = quantity_t'(cmd_qty_q[k]);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= next_cmd;
    waited = 0;
    @(negedge clk);
    while (!cmd_ready && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_ready) begin
      $display("Timed out waiting for the DUT to accept command %0d", k);
      stop_on_failure();
    end
    // Transfer happens on this edge
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic check_response();
    int k;
    k = rsp_count;
    if (k >= exp_uid_q.size()) begin
      $display("Response with uid %0d arrived after all expected responses", rsp.uid);
      stop_on_failure();
    end else begin
      check_value("rsp.uid", exp_uid_q[k], int'(rsp.uid));
      check_value("rsp.status", exp_status_q[k], int'(rsp.status));
      case (exp_kind_q[k])
        kind_spread: begin
          check_value("rsp.result.qrybidask.bid_price", exp_f0_q[k],
                      int'(rsp.result.qrybidask.bid_price));
          check_value("rsp.result.qrybidask.ask_price", exp_f1_q[k],
                      int'(rsp.result.qrybidask.ask_price));
        end
        kind_pop: begin
          check_value("rsp.result.poptop.uid", exp_f0_q[k], int'(rsp.result.poptop.uid));
          check_value("rsp.result.poptop.price", exp_f1_q[k], int'(rsp.result.poptop.price));
          check_value("rsp.result.poptop.quantity", exp_f2_q[k],
                      int'(rsp.result.poptop.quantity));
        end
        kind_trade: begin
          check_value("rsp.result.trade.bid_uid", exp_f0_q[k], int'(rsp.result.trade.bid_uid));
          check_value("rsp.result.trade.ask_uid", exp_f1_q[k], int'(rsp.result.trade.ask_uid));
          check_value("rsp.result.trade.quantity", exp_f2_q[k],
                      int'(rsp.result.trade.quantity));
        end
        default: begin
          // Status and uid only
        end
      endcase
      rsp_count++;
    end
  endtask

  // Sampled mid-cycle ahead of the transfer edge
  always @(negedge clk) begin
    if (arst_n && rsp_valid) begin
      // No response may be offered under back-pressure
      assert (rsp_ready) else begin
        $display("The DUT raised rsp_valid while rsp_ready was low at time %0t", $time);
        stop_on_failure();
      end
      check_response();
    end
  end

  initial begin
    int waited;
    load_golden();
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;

    for (int k = 0; k < cmd_op_q.size(); k++) begin
      send_command(k);
    end

    // Last command done and every response seen
    waited = 0;
    while (!(rsp_count == exp_uid_q.size() && cmd_ready) && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!(rsp_count == exp_uid_q.size() && cmd_ready)) begin
      $display("Timed out with %0d of %0d expected responses received and cmd_ready %0b",
               rsp_count, exp_uid_q.size(), cmd_ready);
      stop_on_failure();
    end
    // Quiet window to catch stray responses
    repeat (20) @(negedge clk);

    if (rsp_count == exp_uid_q.size() && cmd_ready) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("The DUT did not stay idle after the last command");
      stop_on_failure();
    end
  end

endmodule

// File: design/ob_top.sv
// Order book top level
// Controller, match stage and the bid and ask tables

module ob_top (
  input  logic         clk,
  input  logic         arst_n,
  input  logic         cmd_valid,
  input  ob_pkg::cmd_t cmd,
  output logic         cmd_ready,
  output logic         rsp_valid,
  output ob_pkg::rsp_t rsp,
  input  logic         rsp_ready
);

  import ob_pkg::*;

  // Table heads and status
  logic      bid_head_vld;
  logic      ask_head_vld;
  logic      bid_full;
  logic      ask_full;
  entry_t    bid_head;
  entry_t    ask_head;

  // Table strobes
  logic      bid_insert;
  logic      ask_insert;
  logic      bid_pop;
  logic      ask_pop;
  logic      bid_update;
  logic      ask_update;
  entry_t    insert_entry;
  quantity_t update_qty;

  // Match stage
  logic      match_capture;
  match_t    match;

  ob_cntrl u_cntrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .cmd_ready     (cmd_ready),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp),
    .rsp_ready     (rsp_ready),
    .bid_head_vld  (bid_head_vld),
    .ask_head_vld  (ask_head_vld),
    .bid_full      (bid_full),
    .ask_full      (ask_full),
    .bid_head      (bid_head),
    .ask_head      (ask_head),
    .match         (match),
    .match_capture (match_capture),
    .bid_insert    (bid_insert),
    .ask_insert    (ask_insert),
    .bid_pop       (bid_pop),
    .ask_pop       (ask_pop),
    .bid_update    (bid_update),
    .ask_update    (ask_update),
    .insert_entry  (insert_entry),
    .update_qty    (update_qty)
  );

  ob_match u_match (
    .clk      (clk),
    .arst_n   (arst_n),
    .capture  (match_capture),
    .bid_vld  (bid_head_vld),
    .ask_vld  (ask_head_vld),
    .bid_head (bid_head),
    .ask_head (ask_head),
    .match    (match)
  );

  // Bids, highest price first
  ob_book_table #(.is_bid(1'b1)) u_bid_table (
    .clk          (clk),
    .arst_n       (arst_n),
    .insert       (bid_insert),
    .insert_entry (insert_entry),
    .pop          (bid_pop),
    .update       (bid_update),
    .update_qty   (update_qty),
    .head_vld     (bid_head_vld),
    .head         (bid_head),
    .full         (bid_full)
  );

  // Asks, lowest price first
  ob_book_table #(.is_bid(1'b0)) u_ask_table (
    .clk          (clk),
    .arst_n       (arst_n),
    .insert       (ask_insert),
    .insert_entry (insert_entry),
    .pop          (ask_pop),
    .update       (ask_update),
    .update_qty   (update_qty),
    .head_vld     (ask_head_vld),
    .head         (ask_head),
    .full         (ask_full)
  );

endmodule

// File: design/ob_cntrl.sv
// Order book controller
// Command latch and FSM steering the tables, the match stage and responses

`include "ob_defs.svh"

module ob_cntrl (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              cmd_valid,
  input  ob_pkg::cmd_t      cmd,
  output logic              cmd_ready,
  output logic              rsp_valid,
  output ob_pkg::rsp_t      rsp,
  input  logic              rsp_ready,
  input  logic              bid_head_vld,
  input  logic              ask_head_vld,
  input  logic              bid_full,
  input  logic              ask_full,
  input  ob_pkg::entry_t    bid_head,
  input  ob_pkg::entry_t    ask_head,
  input  ob_pkg::match_t    match,
  output logic              match_capture,
  output logic              bid_insert,
  output logic              ask_insert,
  output logic              bid_pop,
  output logic              ask_pop,
  output logic              bid_update,
  output logic              ask_update,
  output ob_pkg::entry_t    insert_entry,
  output ob_pkg::quantity_t update_qty
);

  import ob_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE_QRY,
    EXECUTE
  } state_t;

  state_t state;
  state_t state_next;

  // Command latch
  logic init_done;
  logic cmd_latch_vld;
  cmd_t cmd_latch;
  logic cmd_fetch;
  logic cmd_consume;

  // Held off until the first edge out of reset
  assign cmd_ready = init_done && (!cmd_latch_vld || cmd_consume);
  assign cmd_fetch = cmd_valid && cmd_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      init_done     <= 1'b0;
      cmd_latch_vld <= 1'b0;
      state         <= IDLE;
    end else begin
      init_done <= 1'b1;
      state     <= state_next;
      if (cmd_fetch) begin
        cmd_latch_vld <= 1'b1;
      end else if (cmd_consume) begin
        cmd_latch_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fetch) begin
      cmd_latch <= cmd;
    end
  end

  // Order to rest, uid taken from the command
  always_comb begin
    insert_entry          = cmd_latch.operand;
    insert_entry.uid      = cmd_latch.uid;
  end

  // Remainder goes to whichever head survives
  assign update_qty = match.remainder;

  always_comb begin
    state_next    = state;
    cmd_consume   = 1'b0;
    rsp_valid     = 1'b0;
    rsp           = '0;
    match_capture = 1'b0;
    bid_insert    = 1'b0;
    ask_insert    = 1'b0;
    bid_pop       = 1'b0;
    ask_pop       = 1'b0;
    bid_update    = 1'b0;
    ask_update    = 1'b0;

    case (state)
      IDLE: begin
        // Every command answers at once, so wait on rsp_ready
        if (cmd_latch_vld && rsp_ready) begin
          rsp_valid  = 1'b1;
          rsp.uid    = cmd_latch.uid;
          rsp.status = S_Okay;
          case (cmd_latch.opcode)
            Op_Nop: begin
              cmd_consume = 1'b1;
            end
            Op_QryBidAsk: begin
              cmd_consume                  = 1'b1;
              rsp.result.qrybidask.bid_price = bid_head.price;
              rsp.result.qrybidask.ask_price = ask_head.price;
              // Spread only defined with both sides resting
              if (!(bid_head_vld && ask_head_vld)) begin
                rsp.status = S_Bad;
              end
            end
            Op_Buy: begin
              if (bid_full) begin
                rsp.status  = S_Full;
                cmd_consume = 1'b1;
              end else begin
                bid_insert = 1'b1;
                state_next = ISSUE_QRY;
              end
            end
            Op_Sell: begin
              if (ask_full) begin
                rsp.status  = S_Full;
                cmd_consume = 1'b1;
              end else begin
                ask_insert = 1'b1;
                state_next = ISSUE_QRY;
              end
            end
            Op_PopTopBid: begin
              cmd_consume       = 1'b1;
              rsp.result.poptop = bid_head;
              bid_pop           = bid_head_vld;
              if (!bid_head_vld) begin
                rsp.status = S_BadPop;
              end
            end
            Op_PopTopAsk: begin
              cmd_consume       = 1'b1;
              rsp.result.poptop = ask_head;
              ask_pop           = ask_head_vld;
              if (!ask_head_vld) begin
                rsp.status = S_BadPop;
              end
            end
            default: begin
              // Unknown opcode
              cmd_consume = 1'b1;
              rsp.status  = S_Bad;
            end
          endcase
        end
      end

      ISSUE_QRY: begin
        // Heads now reflect the last insert or trade
        match_capture = 1'b1;
        state_next    = EXECUTE;
      end

      EXECUTE: begin
        if (rsp_ready) begin
          if (match.vld) begin
            // Trade report
            rsp_valid                 = 1'b1;
            rsp.uid                   = `OB_UID_NONE;
            rsp.status                = S_Okay;
            rsp.result.trade.bid_uid  = bid_head.uid;
            rsp.result.trade.ask_uid  = ask_head.uid;
            rsp.result.trade.quantity = match.quantity;

            // Retire consumed heads, trim the survivor
            bid_pop    = match.bid_consumed;
            ask_pop    = match.ask_consumed;
            bid_update = !match.bid_consumed;
            ask_update = !match.ask_consumed;
            state_next = ISSUE_QRY;
          end else begin
            // Book no longer crosses
            cmd_consume = 1'b1;
            state_next  = IDLE;
          end
        end
      end

      default: begin
        state_next = IDLE;
      end
    endcase
  end

endmodule

// File: design/ob_match.sv
// Match stage for the bid and ask heads
// Registers trade decision, traded quantity and remainder

module ob_match (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           capture,
  input  logic           bid_vld,
  input  logic           ask_vld,
  input  ob_pkg::entry_t bid_head,
  input  ob_pkg::entry_t ask_head,
  output ob_pkg::match_t match
);

  import ob_pkg::*;

  logic      can_trade;
  logic      bid_le;
  logic      ask_le;
  quantity_t bid_q;
  quantity_t ask_q;
  match_t    match_next;

  always_comb begin
    bid_q = bid_head.quantity;
    ask_q = ask_head.quantity;

    // Prices cross or touch
    can_trade = bid_vld && ask_vld && (bid_head.price >= ask_head.price);

    // Smaller side is consumed, both on a tie
    bid_le = (bid_q <= ask_q);
    ask_le = (ask_q <= bid_q);

    match_next.vld          = can_trade;
    match_next.bid_consumed = can_trade && bid_le;
    match_next.ask_consumed = can_trade && ask_le;

    // Traded amount and what is left on the survivor
    if (bid_le) begin
      match_next.quantity  = bid_q;
      match_next.remainder = ask_q - bid_q;
    end else begin
      match_next.quantity  = ask_q;
      match_next.remainder = bid_q - ask_q;
    end
  end

  // Registered to keep the compare off the table strobe path
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      match <= '0;
    end else if (capture) begin
      match <= match_next;
    end
  end

endmodule

// File: design/ob_book_table.sv
// Sorted table of resting orders for one side of the book
// Best price at the head, equal prices kept in arrival order

`include "ob_defs.svh"

module ob_book_table #(
  parameter bit is_bid = 1'b1
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              insert,
  input  ob_pkg::entry_t    insert_entry,
  input  logic              pop,
  input  logic              update,
  input  ob_pkg::quantity_t update_qty,
  output logic              head_vld,
  output ob_pkg::entry_t    head,
  output logic              full
);

  import ob_pkg::*;

  // Occupancy is always contiguous from slot 0
  logic [`OB_TABLE_DEPTH-1:0] vld;
  entry_t                     entries [`OB_TABLE_DEPTH];

  // New entry lands here
  logic [`OB_TABLE_DEPTH-1:0] ins_here;
  // Slot takes its upper neighbour
  logic [`OB_TABLE_DEPTH-1:0] ins_shift;

  always_comb begin : place_proc
    logic seen;
    logic ahead;
    seen = 1'b0;
    for (int i = 0; i < `OB_TABLE_DEPTH; i++) begin
      // Strictly better price goes in front and equal goes behind
      if (is_bid) begin
        ahead = !vld[i] || (insert_entry.price > entries[i].price);
      end else begin
        ahead = !vld[i] || (insert_entry.price < entries[i].price);
      end
      ins_here[i]  = ahead && !seen;
      ins_shift[i] = seen;
      seen         = seen || ahead;
    end
  end

  // Valid bits grow on insert and shrink on pop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld <= '0;
    end else if (insert) begin
      vld <= {vld[`OB_TABLE_DEPTH-2:0], 1'b1};
    end else if (pop) begin
      vld <= {1'b0, vld[`OB_TABLE_DEPTH-1:1]};
    end
  end

  for (genvar i = 0; i < `OB_TABLE_DEPTH; i++) begin : g_slot
    entry_t above;
    entry_t below;

    // Nothing lies beyond either end of the table
    if (i == 0) begin : g_first
      assign above = '0;
    end else begin : g_inner_above
      assign above = entries[i-1];
    end

    if (i == `OB_TABLE_DEPTH - 1) begin : g_last
      assign below = '0;
    end else begin : g_inner_below
      assign below = entries[i+1];
    end

    // Entry payload of this slot
    always_ff @(posedge clk) begin
      if (insert && ins_here[i]) begin
        entries[i] <= insert_entry;
      end else if (insert && ins_shift[i]) begin
        entries[i] <= above;
      end else if (pop) begin
        entries[i] <= below;
      end else if (update && (i == 0)) begin
        // Partial fill at the head
        entries[i].quantity <= update_qty;
      end
    end
  end

  assign head_vld = vld[0];
  assign head     = entries[0];
  assign full     = vld[`OB_TABLE_DEPTH-1];

endmodule

// File: design/ob_pkg.sv
// Order book package
// Opcodes, statuses, table entries, commands and responses

`include "ob_defs.svh"

package ob_pkg;

  // Basic fields
  typedef logic [`OB_UID_W-1:0] uid_t;
  typedef logic [`OB_PRICE_W-1:0] price_t;
  typedef logic [`OB_QTY_W-1:0] quantity_t;

  // Command opcodes
  typedef enum logic [2:0] {
    Op_Nop       = 3'd0,
    Op_QryBidAsk = 3'd1,
    Op_Buy       = 3'd2,
    Op_Sell      = 3'd3,
    Op_PopTopBid = 3'd4,
    Op_PopTopAsk = 3'd5
  } opcode_t;

  // Response status
  typedef enum logic [2:0] {
    S_Okay   = 3'd0,
    S_Bad    = 3'd1,
    S_BadPop = 3'd2,
    S_Full   = 3'd3
  } status_t;

  // Resting order, also the command operand
  typedef struct packed {
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } entry_t;

  typedef struct packed {
    opcode_t opcode;
    uid_t    uid;
    entry_t  operand;
  } cmd_t;

  // Spread view of the result word
  typedef struct packed {
    price_t                                       bid_price;
    price_t                                       ask_price;
    logic [$bits(entry_t)-2*$bits(price_t)-1:0]   pad;
  } result_qrybidask_t;

  // Trade view of the result word
  typedef struct packed {
    uid_t                                                      bid_uid;
    uid_t                                                      ask_uid;
    quantity_t                                                 quantity;
    logic [$bits(entry_t)-2*$bits(uid_t)-$bits(quantity_t)-1:0] pad;
  } result_trade_t;

  // One result word, decoded per response kind
  typedef union packed {
    result_qrybidask_t qrybidask;
    entry_t            poptop;
    result_trade_t     trade;
  } result_t;

  typedef struct packed {
    uid_t    uid;
    status_t status;
    result_t result;
  } rsp_t;

  // Outcome of a head-to-head comparison
  typedef struct packed {
    logic      vld;
    logic      bid_consumed;
    logic      ask_consumed;
    quantity_t quantity;
    quantity_t remainder;
  } match_t;

endpackage

// File: design/ob_defs.svh
// Order book widths and sizes
// Shared by the package and the RTL modules

`ifndef OB_DEFS_SVH
`define OB_DEFS_SVH

// Order identifier width
`define OB_UID_W 8

// Price width
`define OB_PRICE_W 10

// Quantity width
`define OB_QTY_W 8

// Resting entries per side
`define OB_TABLE_DEPTH 4

// Trade reports have no originator, so they carry all ones
`define OB_UID_NONE {`OB_UID_W{1'b1}}

`endif
